// File: rtl/ntm_operation_pkg.sv
// Scalar unit operation codes
// Also holds the default operand width for the top level and the testbench
package ntm_operation_pkg;

  ////////////////////
  // Operand width
  ////////////////////

  // Default width of data_a, data_b, modulo and data_out
  localparam int DATA_SIZE_DEFAULT = 8;

  ////////////////////
  // Operation codes
  ////////////////////

  // Encoding 2'b11 is unused and falls back to a plain reduction
  typedef enum logic [1:0] {
    // data_a mod modulo
    OP_MOD = 2'd0,
    // (data_a + data_b) mod modulo
    OP_ADD = 2'd1,
    // (data_a * data_b) mod modulo
    OP_MUL = 2'd2
  } operation_t;

endpackage

// File: rtl/ntm_fsm_pkg.sv
// Controller states for the iterative scalar arithmetic blocks
// Shared by the modulo block, the adder and the multiplier
package ntm_fsm_pkg;

  ////////////////////
  // State encoding
  ////////////////////

  // Modulo block uses STARTER and REDUCE only
  // Multiplier walks all three
  typedef enum logic [1:0] {
    // Idle, waiting for start
    STARTER_STATE = 2'd0,
    // Shift-and-add accumulation
    PREPARE_STATE = 2'd1,
    // Subtracting, or waiting on the inner modulo block
    REDUCE_STATE  = 2'd2
  } scalar_state_t;

endpackage

// File: rtl/ntm_scalar_mod.sv
// Scalar modulo block reducing data mod modulo by repeated subtraction
`timescale 1ns/1ps

module ntm_scalar_mod #(
  parameter int data_size = 8
) (
  input  logic                 CLK,
  input  logic                 RST,
  // Control
  input  logic                 start,
  output logic                 ready,
  // Data
  input  logic [data_size-1:0] modulo,
  input  logic [data_size-1:0] data,
  output logic [data_size-1:0] data_out
);

  ////////////////////
  // Signals
  ////////////////////

  // Controller
  ntm_fsm_pkg::scalar_state_t state;

  // Working remainder
  logic [data_size-1:0] work;

  // Done conditions on the current remainder
  logic mod_zero;
  logic hit_zero;
  logic below;

  assign mod_zero = (modulo == '0);
  assign hit_zero = (work == '0) || (work == modulo);
  assign below    = (work < modulo);

  ////////////////////
  // Controller
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ntm_fsm_pkg::STARTER_STATE;
      ready    <= 1'b0;
      data_out <= '0;
    end else begin
      case (state)
        ntm_fsm_pkg::STARTER_STATE: begin
          // Drop the pulse of the last result
          ready <= 1'b0;
          if (start) begin
            state <= ntm_fsm_pkg::REDUCE_STATE;
          end
        end
        ntm_fsm_pkg::REDUCE_STATE: begin
          if (mod_zero) begin
            // Value passes through unreduced
            data_out <= work;
            ready    <= 1'b1;
            state    <= ntm_fsm_pkg::STARTER_STATE;
          end else if (hit_zero) begin
            data_out <= '0;
            ready    <= 1'b1;
            state    <= ntm_fsm_pkg::STARTER_STATE;
          end else if (below) begin
            // Remainder found
            data_out <= work;
            ready    <= 1'b1;
            state    <= ntm_fsm_pkg::STARTER_STATE;
          end
        end
        default: begin
          ready <= 1'b0;
          state <= ntm_fsm_pkg::STARTER_STATE;
        end
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  // Capture at start, then one subtraction per cycle
  always_ff @(posedge CLK) begin
    if (state == ntm_fsm_pkg::STARTER_STATE && start) begin
      work <= data;
    end else if (state == ntm_fsm_pkg::REDUCE_STATE && !mod_zero && !hit_zero && !below) begin
      work <= work - modulo;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Ready is a single-cycle pulse
  ready_pulse_a: assert property (@(posedge CLK) disable iff (RST) ready |=> !ready)
    else $error("ntm_scalar_mod: ready held for two cycles");

  // Parent must wait for ready before a new start
  start_idle_a: assert property (@(posedge CLK) disable iff (RST)
    (state == ntm_fsm_pkg::REDUCE_STATE) |-> !start)
    else $error("ntm_scalar_mod: start during reduction");

endmodule

// File: rtl/ntm_scalar_adder.sv
// Scalar modular adder computing (data_a + data_b) mod modulo
`timescale 1ns/1ps

module ntm_scalar_adder #(
  parameter int data_size = 8
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  output logic                 ready,
  input  logic [data_size-1:0] modulo,
  input  logic [data_size-1:0] data_a,
  input  logic [data_size-1:0] data_b,
  output logic [data_size-1:0] data_out
);

  ////////////////////
  // Signals
  ////////////////////

  ntm_fsm_pkg::scalar_state_t state;

  // Carry-extended sum and widened modulus
  logic [data_size:0] sum_int;
  logic [data_size:0] modulo_int;

  // Inner modulo block handshake
  logic               mod_start;
  logic               mod_ready;
  logic [data_size:0] mod_out;

  // Sum, modulus and inner start all launch from the start edge
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_fsm_pkg::STARTER_STATE;
      mod_start <= 1'b0;
    end else begin
      mod_start <= 1'b0;
      case (state)
        ntm_fsm_pkg::STARTER_STATE: begin
          if (start) begin
            mod_start <= 1'b1;
            state     <= ntm_fsm_pkg::REDUCE_STATE;
          end
        end
        ntm_fsm_pkg::REDUCE_STATE: begin
          // Wait for the remainder
          if (mod_ready) begin
            state <= ntm_fsm_pkg::STARTER_STATE;
          end
        end
        default: state <= ntm_fsm_pkg::STARTER_STATE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == ntm_fsm_pkg::STARTER_STATE && start) begin
      sum_int    <= {1'b0, data_a} + {1'b0, data_b};
      modulo_int <= {1'b0, modulo};
    end
  end

  // Reduction at one extra bit so the carry is kept
  ntm_scalar_mod #(
    .data_size (data_size + 1)
  ) mod0 (
    .CLK      (CLK),
    .RST      (RST),
    .start    (mod_start),
    .ready    (mod_ready),
    .modulo   (modulo_int),
    .data     (sum_int),
    .data_out (mod_out)
  );

  // Result truncated back to operand width
  assign ready    = mod_ready;
  assign data_out = mod_out[data_size-1:0];

  inner_ready_a: assert property (@(posedge CLK) disable iff (RST)
    mod_ready |-> (state == ntm_fsm_pkg::REDUCE_STATE))
    else $error("ntm_scalar_adder: inner ready outside reduction");

endmodule

// File: rtl/ntm_scalar_multiplier.sv
// Scalar modular multiplier computing (data_a * data_b) mod modulo
// Shift-and-add product followed by reduction at double width
`timescale 1ns/1ps

module ntm_scalar_multiplier #(
  parameter int data_size = 8
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  output logic                 ready,
  input  logic [data_size-1:0] modulo,
  input  logic [data_size-1:0] data_a,
  input  logic [data_size-1:0] data_b,
  output logic [data_size-1:0] data_out
);

  localparam int cnt_width = $clog2(data_size + 1);
  localparam logic [cnt_width-1:0] last_bit = cnt_width'(data_size - 1);

  ////////////////////
  // Signals
  ////////////////////

  ntm_fsm_pkg::scalar_state_t state;
  logic [cnt_width-1:0]       bit_cnt;

  // Shifted multiplicand, remaining multiplier bits, running product
  logic [2*data_size-1:0] mcand;
  logic [data_size-1:0]   mplier;
  logic [2*data_size-1:0] product;
  logic [2*data_size-1:0] modulo_int;

  // Inner modulo block
  logic                   mod_start;
  logic                   mod_ready;
  logic [2*data_size-1:0] mod_out;

  ////////////////////
  // Controller
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_fsm_pkg::STARTER_STATE;
      bit_cnt   <= '0;
      mod_start <= 1'b0;
    end else begin
      mod_start <= 1'b0;
      case (state)
        ntm_fsm_pkg::STARTER_STATE: begin
          if (start) begin
            bit_cnt <= '0;
            state   <= ntm_fsm_pkg::PREPARE_STATE;
          end
        end
        ntm_fsm_pkg::PREPARE_STATE: begin
          // Last partial product lands on this edge
          if (bit_cnt == last_bit) begin
            mod_start <= 1'b1;
            state     <= ntm_fsm_pkg::REDUCE_STATE;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        ntm_fsm_pkg::REDUCE_STATE: begin
          if (mod_ready) begin
            state <= ntm_fsm_pkg::STARTER_STATE;
          end
        end
        default: state <= ntm_fsm_pkg::STARTER_STATE;
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge CLK) begin
    if (state == ntm_fsm_pkg::STARTER_STATE && start) begin
      mcand      <= {{data_size{1'b0}}, data_a};
      mplier     <= data_b;
      product    <= '0;
      modulo_int <= {{data_size{1'b0}}, modulo};
    end else if (state == ntm_fsm_pkg::PREPARE_STATE) begin
      // Add the multiplicand when the low multiplier bit is set
      if (mplier[0]) begin
        product <= product + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  ntm_scalar_mod #(
    .data_size (2 * data_size)
  ) mod0 (
    .CLK      (CLK),
    .RST      (RST),
    .start    (mod_start),
    .ready    (mod_ready),
    .modulo   (modulo_int),
    .data     (product),
    .data_out (mod_out)
  );

  // Low half only
  assign ready    = mod_ready;
  assign data_out = mod_out[data_size-1:0];

  bit_cnt_range_a: assert property (@(posedge CLK) disable iff (RST)
    bit_cnt < data_size)
    else $error("ntm_scalar_multiplier: bit counter out of range");

endmodule

// File: rtl/ntm_scalar_unit.sv
// Scalar modular arithmetic unit
// Routes start to the mod, add or mul block and returns its result
`timescale 1ns/1ps

module ntm_scalar_unit #(
  parameter int data_size = ntm_operation_pkg::DATA_SIZE_DEFAULT
) (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           start,
  input  ntm_operation_pkg::operation_t  operation,
  input  logic [data_size-1:0]           data_a,
  input  logic [data_size-1:0]           data_b,
  input  logic [data_size-1:0]           modulo,
  output logic                           ready,
  output logic [data_size-1:0]           data_out
);

  ////////////////////
  // Signals
  ////////////////////

  logic                          busy;
  logic                          accept;
  ntm_operation_pkg::operation_t op_held;

  // Per-block handshake and results
  logic                 mod_start;
  logic                 add_start;
  logic                 mul_start;
  logic                 mod_ready;
  logic                 add_ready;
  logic                 mul_ready;
  logic [data_size-1:0] mod_result;
  logic [data_size-1:0] add_result;
  logic [data_size-1:0] mul_result;

  // Starts while busy are dropped
  assign accept = start && !busy;

  // Unused code 2'b11 goes to the modulo block
  assign add_start = accept && (operation == ntm_operation_pkg::OP_ADD);
  assign mul_start = accept && (operation == ntm_operation_pkg::OP_MUL);
  assign mod_start = accept && !add_start && !mul_start;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      op_held <= ntm_operation_pkg::OP_MOD;
    end else if (accept) begin
      busy    <= 1'b1;
      op_held <= operation;
    end else if (ready) begin
      busy <= 1'b0;
    end
  end

  ////////////////////
  // Arithmetic blocks
  ////////////////////

  ntm_scalar_mod #(.data_size(data_size)) mod0 (
    .CLK(CLK), .RST(RST), .start(mod_start), .ready(mod_ready),
    .modulo(modulo), .data(data_a), .data_out(mod_result)
  );

  ntm_scalar_adder #(.data_size(data_size)) adder0 (
    .CLK(CLK), .RST(RST), .start(add_start), .ready(add_ready),
    .modulo(modulo), .data_a(data_a), .data_b(data_b), .data_out(add_result)
  );

  ntm_scalar_multiplier #(.data_size(data_size)) multiplier0 (
    .CLK(CLK), .RST(RST), .start(mul_start), .ready(mul_ready),
    .modulo(modulo), .data_a(data_a), .data_b(data_b), .data_out(mul_result)
  );

  // Only one block is ever running
  assign ready = mod_ready | add_ready | mul_ready;

  // Result of the operation last accepted
  always_comb begin
    case (op_held)
      ntm_operation_pkg::OP_ADD: data_out = add_result;
      ntm_operation_pkg::OP_MUL: data_out = mul_result;
      default:                   data_out = mod_result;
    endcase
  end

endmodule

// File: verif/ntm_scalar_checker.sv
// Result checker for the scalar modular arithmetic unit
// Samples each accepted start and compares data_out at ready against a model
`timescale 1ns/1ps

module ntm_scalar_checker #(
  parameter int data_size = ntm_operation_pkg::DATA_SIZE_DEFAULT
) (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          start,
  input  ntm_operation_pkg::operation_t operation,
  input  logic [data_size-1:0]          data_a,
  input  logic [data_size-1:0]          data_b,
  input  logic [data_size-1:0]          modulo,
  input  logic                          ready,
  input  logic [data_size-1:0]          data_out,
  output int                            test_count,
  output int                            fail_count
);

  // Operation in flight, as seen from the ports
  logic                          busy_m;
  logic                          accept;
  logic                          seen_start;
  logic                          reset_bad;
  ntm_operation_pkg::operation_t op_s;
  logic [data_size-1:0]          a_s;
  logic [data_size-1:0]          b_s;
  logic [data_size-1:0]          m_s;
  logic [data_size-1:0]          expected;

  // Double-width arithmetic, reduced only for a nonzero modulus
  function automatic logic [data_size-1:0] expected_result(
    input ntm_operation_pkg::operation_t op,
    input logic [data_size-1:0]          a,
    input logic [data_size-1:0]          b,
    input logic [data_size-1:0]          m);
    logic [2*data_size-1:0] wa;
    logic [2*data_size-1:0] wb;
    logic [2*data_size-1:0] wm;
    logic [2*data_size-1:0] full;
    wa = {{data_size{1'b0}}, a};
    wb = {{data_size{1'b0}}, b};
    wm = {{data_size{1'b0}}, m};
    case (op)
      ntm_operation_pkg::OP_ADD: full = wa + wb;
      ntm_operation_pkg::OP_MUL: full = wa * wb;
      default:                   full = wa;
    endcase
    if (wm != '0) begin
      full = full % wm;
    end
    return full[data_size-1:0];
  endfunction

  always @(posedge CLK) begin
    if (RST) begin
      busy_m     = 1'b0;
      seen_start = 1'b0;
      reset_bad  = 1'b0;
      test_count = 0;
      fail_count = 0;
    end else begin
      // Busy as it was before this edge
      accept = start && !busy_m;
      if (!seen_start && (ready !== 1'b0 || data_out !== '0)) begin
        reset_bad = 1'b1;
      end
      if (ready === 1'b1) begin
        if (!busy_m) begin
          fail_count++;
          $display("Error at time %0t: ready pulse with no operation in flight", $time);
        end else begin
          busy_m = 1'b0;
          test_count++;
          if (data_out !== expected) begin
            fail_count++;
            $display("[FAIL] time %0t: %s a=%0d b=%0d modulo=%0d expected %0d got %0d",
                     $time, op_s.name(), a_s, b_s, m_s, expected, data_out);
          end else begin
            $display("[PASS] test %0d: %s a=%0d b=%0d modulo=%0d result %0d",
                     test_count, op_s.name(), a_s, b_s, m_s, data_out);
          end
        end
      end
      if (accept) begin
        // Idle window after reset ends with the first start
        if (!seen_start) begin
          seen_start = 1'b1;
          test_count++;
          if (reset_bad) begin
            fail_count++;
            $display("[FAIL] time %0t: ready or data_out not idle after reset", $time);
          end else begin
            $display("[PASS] test %0d: idle outputs after reset", test_count);
          end
        end
        busy_m   = 1'b1;
        op_s     = operation;
        a_s      = data_a;
        b_s      = data_b;
        m_s      = modulo;
        expected = expected_result(operation, data_a, data_b, modulo);
      end
    end
  end

endmodule

// File: verif/ntm_scalar_unit_tb.sv
// Testbench for the scalar modular arithmetic unit
// Directed and xorshift random operations, results checked by ntm_scalar_checker
`timescale 1ns/1ps

module ntm_scalar_unit_tb;

  localparam int data_size   = ntm_operation_pkg::DATA_SIZE_DEFAULT;
  localparam int num_random  = 40;
  localparam int num_tests   = 8 + num_random;
  // Longest reduction, shift-and-add, handshake and idle gap per test
  localparam int cycle_limit = num_tests * (4096 + 8 + 1 + 4) + 100;

  logic                          CLK;
  logic                          RST;
  logic                          start;
  ntm_operation_pkg::operation_t operation;
  logic [data_size-1:0]          data_a;
  logic [data_size-1:0]          data_b;
  logic [data_size-1:0]          modulo;
  logic                          ready;
  logic [data_size-1:0]          data_out;

  // Random state and run bookkeeping
  logic [31:0] rng;
  int          cycle_count;
  int          test_count;
  int          fail_count;

  ntm_scalar_unit #(.data_size(data_size)) dut0 (
    .CLK(CLK), .RST(RST), .start(start), .operation(operation),
    .data_a(data_a), .data_b(data_b), .modulo(modulo),
    .ready(ready), .data_out(data_out)
  );

  ntm_scalar_checker #(.data_size(data_size)) checker0 (
    .CLK(CLK), .RST(RST), .start(start), .operation(operation),
    .data_a(data_a), .data_b(data_b), .modulo(modulo),
    .ready(ready), .data_out(data_out),
    .test_count(test_count), .fail_count(fail_count)
  );

  ////////////////////
  // Clock and watchdog
  ////////////////////

  // 20 ns period
  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles: the DUT never answered with ready", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  // One start pulse, wait for ready, then a short idle gap
  task automatic run_op(input ntm_operation_pkg::operation_t op,
                        input logic [data_size-1:0] a,
                        input logic [data_size-1:0] b,
                        input logic [data_size-1:0] m);
    @(posedge CLK);
    start     <= 1'b1;
    operation <= op;
    data_a    <= a;
    data_b    <= b;
    modulo    <= m;
    @(posedge CLK);
    start <= 1'b0;
    // Products run at least data_size cycles, so a stray start lands while busy
    if (op == ntm_operation_pkg::OP_MUL) begin
      @(posedge CLK);
      start     <= 1'b1;
      operation <= ntm_operation_pkg::OP_ADD;
      data_b    <= ~b;
      @(posedge CLK);
      start <= 1'b0;
    end
    do begin
      @(posedge CLK);
    end while (ready !== 1'b1);
    // 0 to 3 idle cycles
    rng = xorshift(rng);
    repeat (rng[1:0]) @(posedge CLK);
  endtask

  initial begin
    ntm_operation_pkg::operation_t op;
    logic [data_size-1:0]          a;
    logic [data_size-1:0]          b;
    logic [data_size-1:0]          m;
    RST       <= 1'b1;
    start     <= 1'b0;
    operation <= ntm_operation_pkg::OP_MOD;
    data_a    <= '0;
    data_b    <= '0;
    modulo    <= '0;
    rng = 32'd95;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    // Idle outputs get watched here before the first start
    repeat (2) @(posedge CLK);

    // Edge cases
    run_op(ntm_operation_pkg::OP_MOD, 8'd37, 8'd0, 8'd37);
    run_op(ntm_operation_pkg::OP_MOD, 8'd0, 8'd0, 8'd13);
    run_op(ntm_operation_pkg::OP_MOD, 8'd250, 8'd0, 8'd7);
    run_op(ntm_operation_pkg::OP_ADD, 8'd200, 8'd100, 8'd9);
    // Zero modulus on all three operations
    run_op(ntm_operation_pkg::OP_ADD, 8'd255, 8'd255, 8'd0);
    run_op(ntm_operation_pkg::OP_MUL, 8'd200, 8'd3, 8'd0);
    run_op(ntm_operation_pkg::OP_MOD, 8'd99, 8'd0, 8'd0);
    // Longest product reduction
    run_op(ntm_operation_pkg::OP_MUL, 8'd255, 8'd255, 8'd16);

    for (int i = 0; i < num_random; i++) begin
      rng = xorshift(rng);
      case (rng % 3)
        0:       op = ntm_operation_pkg::OP_MOD;
        1:       op = ntm_operation_pkg::OP_ADD;
        default: op = ntm_operation_pkg::OP_MUL;
      endcase
      a   = rng[7:0];
      b   = rng[15:8];
      rng = xorshift(rng);
      if (rng[2:0] == 3'd0) begin
        m = '0;
      end else if (op == ntm_operation_pkg::OP_MUL) begin
        // Keeps the subtraction count within 4096
        m = 8'd16 + (rng[15:8] % 8'd240);
      end else begin
        m = rng[15:8];
      end
      run_op(op, a, b, m);
    end

    repeat (3) @(posedge CLK);
    $display("Tests run: %0d, passed: %0d, failed checks: %0d",
             test_count, test_count - fail_count, fail_count);
    if (fail_count == 0 && test_count == num_tests + 1) begin
      $display("Simulation passed");
    end else begin
      if (test_count != num_tests + 1) begin
        $display("Expected %0d finished tests but the checker counted %0d",
                 num_tests + 1, test_count);
      end
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: ntm_scalar_unit.f
rtl/ntm_operation_pkg.sv
rtl/ntm_fsm_pkg.sv
rtl/ntm_scalar_mod.sv
rtl/ntm_scalar_adder.sv
rtl/ntm_scalar_multiplier.sv
rtl/ntm_scalar_unit.sv
verif/ntm_scalar_checker.sv
verif/ntm_scalar_unit_tb.sv

// File: Makefile
# Verilator build and run for the scalar modular arithmetic unit
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = ntm_scalar_unit_tb
FILELIST  = ntm_scalar_unit.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
